// File: list.f
rv_isa_pkg.sv
rv_core_pkg.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_exec_core.sv
rv_exec_core_props.sv
tb_rv_exec_core.sv

// File: Bender.yml
package:
  name: rv_exec_core

sources:
  - rv_isa_pkg.sv
  - rv_core_pkg.sv
  - rv_decode.sv
  - rv_execute.sv
  - rv_result.sv
  - rv_exec_core.sv
  - target: test
    files:
      - rv_exec_core_props.sv
      - tb_rv_exec_core.sv

// File: tb_rv_exec_core.sv
`timescale 1ns/10ps

module tb_rv_exec_core import rv_isa_pkg::*, rv_core_pkg::*; ();

    localparam int CLK_PERIOD  = 10;
    localparam int INST_BUDGET = 300;  // upper bound on issued instructions

    logic            clk;
    logic            reset;
    logic            inst_valid;
    inst_t           inst;
    logic [XLEN-1:0] pc;
    logic            wb_valid;
    reg_addr_t       wb_rd;
    logic [XLEN-1:0] wb_data;
    logic            redirect_valid;
    logic [XLEN-1:0] redirect_pc;
    logic            trap_valid;
    trap_e           trap_cause;
    logic [XLEN-1:0] trap_pc;

    integer          seed = 32'h9f6a;
    logic [XLEN-1:0] cur_pc;
    logic [XLEN-1:0] mregs [NUM_REGS];  // architectural register model
    int              wb_errs;
    int              redir_errs;
    int              trap_errs;

    logic [68:0] got_wb [$];  // {rd, data}
    logic [68:0] exp_wb [$];
    logic [63:0] got_redir [$];
    logic [63:0] exp_redir [$];
    logic [65:0] got_trap [$];  // {cause, pc}
    logic [65:0] exp_trap [$];

    rv_exec_core rv_exec_core_i (
        .clk            (clk),
        .reset          (reset),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .pc             (pc),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .trap_valid     (trap_valid),
        .trap_cause     (trap_cause),
        .trap_pc        (trap_pc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(negedge clk) begin  // outputs settled mid-cycle
        if (!reset) begin
            if (wb_valid)
                got_wb.push_back({wb_rd, wb_data});
            if (redirect_valid)
                got_redir.push_back(redirect_pc);
            if (trap_valid)
                got_trap.push_back({trap_cause, trap_pc});
        end
    end

    function automatic inst_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t u_type(input logic [19:0] imm, input logic [4:0] rd,
                                     input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic inst_t j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic inst_t b_type(input logic [12:0] off, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    // RV64I arithmetic, word forms take 32 bits and a 5-bit shift
    function automatic logic [63:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic word, input logic [63:0] a,
                                            input logic [63:0] b);
        logic [63:0] r;
        logic [31:0] w;
        logic [5:0]  sh;
        sh = word ? {1'b0, b[4:0]} : b[5:0];
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << sh;
            3'd2: r = {63'b0, $signed(a) < $signed(b)};
            3'd3: r = {63'b0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                if (word) begin
                    if (alt)
                        w = $signed(a[31:0]) >>> sh;
                    else
                        w = a[31:0] >> sh;
                    r = {32'b0, w};
                end else if (alt) begin
                    r = $signed(a) >>> sh;
                end else begin
                    r = a >> sh;
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        if (word)
            r = {{32{r[31]}}, r[31:0]};
        return r;
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [63:0] a,
                                          input logic [63:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic issue(input inst_t word);
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= word;
        pc         <= cur_pc;
        cur_pc = cur_pc + 64'd4;
    endtask

    task automatic drain();
        @(posedge clk);
        inst_valid <= 1'b0;
        inst       <= '0;
        repeat (2) @(posedge clk);  // fixed two-edge latency
        @(negedge clk);
    endtask

    task automatic expect_wb(input logic [4:0] rd, input logic [63:0] val);
        if (rd != 5'd0) begin
            exp_wb.push_back({rd, val});
            mregs[rd] = val;
        end
    endtask

    task automatic expect_redirect(input logic [63:0] target);
        exp_redir.push_back(target);
    endtask

    task automatic expect_trap(input trap_e cause, input logic [63:0] at_pc);
        exp_trap.push_back({cause, at_pc});
    endtask

    task automatic run_op(input inst_t word, input logic [4:0] rd, input logic [63:0] val);
        issue(word);
        expect_wb(rd, val);
    endtask

    // addi then five rounds of slli 11 / addi of an 11-bit chunk
    task automatic load_reg(input logic [4:0] rd, input logic [63:0] v);
        logic [63:0] acc;
        acc = {55'b0, v[63:55]};
        run_op(i_type({3'b0, v[63:55]}, 5'd0, 3'd0, rd, OPC_OP_IMM), rd, acc);
        for (int k = 4; k >= 0; k--) begin
            acc = acc << 11;
            run_op(i_type(12'd11, rd, 3'd1, rd, OPC_OP_IMM), rd, acc);
            acc = acc + {53'b0, v[k*11 +: 11]};
            run_op(i_type({1'b0, v[k*11 +: 11]}, rd, 3'd0, rd, OPC_OP_IMM), rd, acc);
        end
    endtask

    task automatic check_results(input string name);
        int n;
        n = (got_wb.size() < exp_wb.size()) ? got_wb.size() : exp_wb.size();
        if (got_wb.size() != exp_wb.size()) begin
            $display("%s: expected %0d writeback pulses but saw %0d",
                     name, exp_wb.size(), got_wb.size());
            wb_errs++;
        end
        for (int i = 0; i < n; i++) begin
            if (got_wb[i] !== exp_wb[i]) begin
                $display("** Error @%0t: %s writeback %0d got x%0d=%h, expected x%0d=%h",
                         $time, name, i, got_wb[i][68:64], got_wb[i][63:0],
                         exp_wb[i][68:64], exp_wb[i][63:0]);
                wb_errs++;
            end
        end
        n = (got_redir.size() < exp_redir.size()) ? got_redir.size() : exp_redir.size();
        if (got_redir.size() != exp_redir.size()) begin
            $display("%s: expected %0d redirect pulses but saw %0d",
                     name, exp_redir.size(), got_redir.size());
            redir_errs++;
        end
        for (int i = 0; i < n; i++) begin
            if (got_redir[i] !== exp_redir[i]) begin
                $display("** Error @%0t: %s redirect %0d got %h, expected %h",
                         $time, name, i, got_redir[i], exp_redir[i]);
                redir_errs++;
            end
        end
        n = (got_trap.size() < exp_trap.size()) ? got_trap.size() : exp_trap.size();
        if (got_trap.size() != exp_trap.size()) begin
            $display("%s: expected %0d trap pulses but saw %0d",
                     name, exp_trap.size(), got_trap.size());
            trap_errs++;
        end
        for (int i = 0; i < n; i++) begin
            if (got_trap[i] !== exp_trap[i]) begin
                $display("** Error @%0t: %s trap %0d got cause %0d pc %h, expected %0d pc %h",
                         $time, name, i, got_trap[i][65:64], got_trap[i][63:0],
                         exp_trap[i][65:64], exp_trap[i][63:0]);
                trap_errs++;
            end
        end
        got_wb.delete();
        exp_wb.delete();
        got_redir.delete();
        exp_redir.delete();
        got_trap.delete();
        exp_trap.delete();
    endtask

    task automatic idle_test();
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_results("idle");
    endtask

    task automatic alu_test();
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] ib;
        logic [11:0] imm;
        logic [5:0]  sh;
        for (int n = 0; n < 3; n++) begin
            a = {$random(seed), $random(seed)};
            b = {$random(seed), $random(seed)};
            load_reg(5'd1, a);
            load_reg(5'd2, b);
            for (int f = 0; f < 8; f++) begin
                run_op(r_type(F7_BASE, 5'd2, 5'd1, 3'(f), 5'd3, OPC_OP), 5'd3,
                       ref_alu(3'(f), 1'b0, 1'b0, a, b));
                if (f == 0 || f == 5)
                    run_op(r_type(F7_ALT, 5'd2, 5'd1, 3'(f), 5'd3, OPC_OP), 5'd3,
                           ref_alu(3'(f), 1'b1, 1'b0, a, b));
            end
            // back-to-back readers of the last result
            run_op(r_type(F7_BASE, 5'd1, 5'd3, 3'd0, 5'd4, OPC_OP), 5'd4,
                   ref_alu(3'd0, 1'b0, 1'b0, mregs[3], a));
            run_op(r_type(F7_BASE, 5'd4, 5'd1, 3'd4, 5'd6, OPC_OP), 5'd6,
                   ref_alu(3'd4, 1'b0, 1'b0, a, mregs[4]));
            for (int f = 0; f < 8; f++) begin
                imm = 12'($random(seed));
                ib  = {{52{imm[11]}}, imm};
                if (f != 1 && f != 5)
                    run_op(i_type(imm, 5'd1, 3'(f), 5'd7, OPC_OP_IMM), 5'd7,
                           ref_alu(3'(f), 1'b0, 1'b0, a, ib));
            end
            sh = 6'($random(seed));
            run_op(i_type({6'b000000, sh}, 5'd1, 3'd1, 5'd8, OPC_OP_IMM), 5'd8,
                   ref_alu(3'd1, 1'b0, 1'b0, a, {58'b0, sh}));
            run_op(i_type({6'b000000, sh}, 5'd1, 3'd5, 5'd8, OPC_OP_IMM), 5'd8,
                   ref_alu(3'd5, 1'b0, 1'b0, a, {58'b0, sh}));
            run_op(i_type({6'b010000, sh}, 5'd1, 3'd5, 5'd8, OPC_OP_IMM), 5'd8,
                   ref_alu(3'd5, 1'b1, 1'b0, a, {58'b0, sh}));
        end
        drain();
        check_results("alu");
    endtask

    task automatic word_test();
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] neg;
        logic [11:0] imm;
        logic [4:0]  sh;
        a   = {$random(seed), $random(seed)};
        b   = {$random(seed), $random(seed)};
        neg = {$random(seed), $random(seed)};
        neg[31] = 1'b1;
        load_reg(5'd1, a);
        load_reg(5'd2, b);
        load_reg(5'd5, neg);
        run_op(r_type(F7_BASE, 5'd2, 5'd1, 3'd0, 5'd3, OPC_OP_32), 5'd3,
               ref_alu(3'd0, 1'b0, 1'b1, a, b));
        run_op(r_type(F7_ALT, 5'd2, 5'd1, 3'd0, 5'd3, OPC_OP_32), 5'd3,
               ref_alu(3'd0, 1'b1, 1'b1, a, b));
        run_op(r_type(F7_BASE, 5'd2, 5'd1, 3'd1, 5'd3, OPC_OP_32), 5'd3,
               ref_alu(3'd1, 1'b0, 1'b1, a, b));
        run_op(r_type(F7_BASE, 5'd2, 5'd1, 3'd5, 5'd3, OPC_OP_32), 5'd3,
               ref_alu(3'd5, 1'b0, 1'b1, a, b));
        run_op(r_type(F7_ALT, 5'd2, 5'd1, 3'd5, 5'd3, OPC_OP_32), 5'd3,
               ref_alu(3'd5, 1'b1, 1'b1, a, b));
        run_op(r_type(F7_BASE, 5'd0, 5'd5, 3'd5, 5'd7, OPC_OP_32), 5'd7,
               ref_alu(3'd5, 1'b0, 1'b1, neg, 64'd0));  // srlw by 0 stays negative
        imm = 12'($random(seed));
        run_op(i_type(imm, 5'd1, 3'd0, 5'd3, OPC_OP_IMM_32), 5'd3,
               ref_alu(3'd0, 1'b0, 1'b1, a, {{52{imm[11]}}, imm}));
        sh = 5'($random(seed));
        run_op(i_type({7'b0000000, sh}, 5'd1, 3'd1, 5'd3, OPC_OP_IMM_32), 5'd3,
               ref_alu(3'd1, 1'b0, 1'b1, a, {59'b0, sh}));
        run_op(i_type({7'b0000000, sh}, 5'd1, 3'd5, 5'd3, OPC_OP_IMM_32), 5'd3,
               ref_alu(3'd5, 1'b0, 1'b1, a, {59'b0, sh}));
        run_op(i_type({7'b0100000, sh}, 5'd5, 3'd5, 5'd3, OPC_OP_IMM_32), 5'd3,
               ref_alu(3'd5, 1'b1, 1'b1, neg, {59'b0, sh}));
        drain();
        check_results("word");
    endtask

    task automatic upper_jump_test();
        logic [19:0] uimm;
        logic [63:0] uval;
        logic [20:0] joff;
        logic [11:0] jimm;
        logic [63:0] p;
        logic [63:0] target;
        uimm = 20'($random(seed));
        uval = {{32{uimm[19]}}, uimm, 12'h000};
        run_op(u_type(uimm, 5'd8, OPC_LUI), 5'd8, uval);
        p = cur_pc;
        run_op(u_type(uimm, 5'd9, OPC_AUIPC), 5'd9, p + uval);
        joff = 21'($random(seed));
        joff[0] = 1'b0;
        p = cur_pc;
        run_op(j_type(joff, 5'd10), 5'd10, p + 64'd4);
        expect_redirect(p + {{43{joff[20]}}, joff});
        jimm = 12'($random(seed));
        jimm[0] = 1'b1;  // forces the low target bit to be cleared
        p = cur_pc;
        target = (mregs[1] + {{52{jimm[11]}}, jimm}) & ~64'd1;
        run_op(i_type(jimm, 5'd1, 3'd0, 5'd1, OPC_JALR), 5'd1, p + 64'd4);
        expect_redirect(target);
        joff = 21'($random(seed));
        joff[0] = 1'b0;
        p = cur_pc;
        issue(j_type(joff, 5'd0));  // link to x0 gives no writeback
        expect_redirect(p + {{43{joff[20]}}, joff});
        issue(i_type(12'd5, 5'd1, 3'd0, 5'd0, OPC_OP_IMM));
        drain();
        check_results("upper_jump");
    endtask

    task automatic branch_test();
        logic [4:0]  pair_a [5];
        logic [4:0]  pair_b [5];
        logic [2:0]  f3s [6];
        logic [12:0] boff;
        logic [63:0] p;
        pair_a = '{5'd1, 5'd2, 5'd1, 5'd12, 5'd13};
        pair_b = '{5'd2, 5'd1, 5'd14, 5'd13, 5'd12};
        f3s    = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        load_reg(5'd1, {$random(seed), $random(seed)});
        load_reg(5'd2, {$random(seed), $random(seed)});
        run_op(i_type(12'hffb, 5'd0, 3'd0, 5'd12, OPC_OP_IMM), 5'd12, 64'hffff_ffff_ffff_fffb);
        run_op(i_type(12'd3, 5'd0, 3'd0, 5'd13, OPC_OP_IMM), 5'd13, 64'd3);
        run_op(i_type(12'd0, 5'd1, 3'd0, 5'd14, OPC_OP_IMM), 5'd14, mregs[1]);
        for (int f = 0; f < 6; f++) begin
            for (int k = 0; k < 5; k++) begin
                boff = 13'($random(seed));
                boff[0] = 1'b0;
                p = cur_pc;
                issue(b_type(boff, pair_b[k], pair_a[k], f3s[f]));
                if (branch_taken(f3s[f], mregs[pair_a[k]], mregs[pair_b[k]]))
                    expect_redirect(p + {{51{boff[12]}}, boff});
            end
        end
        drain();
        check_results("branch");
    endtask

    task automatic trap_test();
        logic [63:0] p;
        p = cur_pc;
        issue(EBREAK_INST);
        expect_trap(TRAP_EBREAK, p);
        p = cur_pc;
        issue(r_type(7'b0000001, 5'd2, 5'd1, 3'd0, 5'd3, OPC_OP));  // mul
        expect_trap(TRAP_ILLEGAL, p);
        run_op(r_type(F7_BASE, 5'd0, 5'd3, 3'd0, 5'd4, OPC_OP), 5'd4, mregs[3]);
        drain();
        check_results("trap");
    endtask

    initial begin
        #((INST_BUDGET * 20 + 200) * CLK_PERIOD);
        $display("watchdog expired before the tests completed");
        $display("Test failures found");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        cur_pc     = 64'h0000_0000_8000_0000;
        wb_errs    = 0;
        redir_errs = 0;
        trap_errs  = 0;
        for (int i = 0; i < NUM_REGS; i++)
            mregs[i] = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        idle_test();
        alu_test();
        word_test();
        upper_jump_test();
        branch_test();
        trap_test();
        $display("errors: writeback %0d, redirect %0d, trap %0d",
                 wb_errs, redir_errs, trap_errs);
        if (wb_errs + redir_errs + trap_errs == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// File: rv_exec_core_props.sv
`timescale 1ns/10ps

module rv_exec_core_props (
    input logic clk,
    input logic reset,
    input logic inst_valid,
    input logic wb_valid,
    input logic redirect_valid,
    input logic trap_valid
);

    logic any_pulse;

    assign any_pulse = wb_valid || redirect_valid || trap_valid;

    quiet_after_reset: assert property (
        @(posedge clk) $past(reset) && !reset |-> !any_pulse
    ) else $error("output pulse in the first cycle after reset");

    // decode edge then result edge
    pulse_latency: assert property (
        @(posedge clk) disable iff (reset) any_pulse |-> $past(inst_valid, 2)
    ) else $error("output pulse without inst_valid two edges earlier");

    trap_no_wb: assert property (
        @(posedge clk) disable iff (reset) !(trap_valid && wb_valid)
    ) else $error("trap and writeback in the same cycle");

endmodule

bind rv_exec_core rv_exec_core_props rv_exec_core_props_i (.*);

// File: rv_exec_core.sv
`timescale 1ns/10ps

module rv_exec_core import rv_core_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            inst_valid,
    input  inst_t           inst,
    input  logic [XLEN-1:0] pc,
    output logic            wb_valid,
    output reg_addr_t       wb_rd,
    output logic [XLEN-1:0] wb_data,
    output logic            redirect_valid,
    output logic [XLEN-1:0] redirect_pc,
    output logic            trap_valid,
    output trap_e           trap_cause,
    output logic [XLEN-1:0] trap_pc
);

    decoded_t        dec;
    exec_result_t    exe;
    reg_addr_t       rs1_addr;
    reg_addr_t       rs2_addr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;

    rv_decode rv_decode_i (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .pc         (pc),
        .dec        (dec)
    );

    rv_execute rv_execute_i (
        .dec      (dec),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .exe      (exe)
    );

    rv_result rv_result_i (
        .clk            (clk),
        .reset          (reset),
        .exe            (exe),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .trap_valid     (trap_valid),
        .trap_cause     (trap_cause),
        .trap_pc        (trap_pc)
    );

endmodule

// File: rv_result.sv
`timescale 1ns/10ps

module rv_result import rv_core_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  exec_result_t    exe,
    input  reg_addr_t       rs1_addr,
    input  reg_addr_t       rs2_addr,
    output logic [XLEN-1:0] rs1_data,
    output logic [XLEN-1:0] rs2_data,
    output logic            wb_valid,
    output reg_addr_t       wb_rd,
    output logic [XLEN-1:0] wb_data,
    output logic            redirect_valid,
    output logic [XLEN-1:0] redirect_pc,
    output logic            trap_valid,
    output trap_e           trap_cause,
    output logic [XLEN-1:0] trap_pc
);

    logic [XLEN-1:0] regs [NUM_REGS];
    logic [XLEN-1:0] wr_data;
    logic            wr_en;

    assign wr_data = exe.word_op ? {{(XLEN-WORD_W){exe.value[WORD_W-1]}},
                                    exe.value[WORD_W-1:0]} : exe.value;
    assign wr_en   = exe.valid && exe.reg_wen && (exe.rd != '0);  // x0 never written

    // prior write lands at the edge that loads the reader
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[exe.rd] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid       <= 1'b0;
            redirect_valid <= 1'b0;
            trap_valid     <= 1'b0;
            trap_cause     <= TRAP_NONE;
        end else begin
            wb_valid       <= wr_en;
            redirect_valid <= exe.valid && exe.redirect;
            trap_valid     <= exe.valid && (exe.trap != TRAP_NONE);
            trap_cause     <= exe.trap;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd       <= exe.rd;
        wb_data     <= wr_data;
        redirect_pc <= exe.target;
        trap_pc     <= exe.pc;
    end

endmodule

// File: rv_execute.sv
`timescale 1ns/10ps

module rv_execute import rv_core_pkg::*; (
    input  decoded_t        dec,
    output reg_addr_t       rs1_addr,
    output reg_addr_t       rs2_addr,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    output exec_result_t    exe
);

    logic [XLEN-1:0]    imm;
    logic [XLEN-1:0]    op_a;
    logic [XLEN-1:0]    op_b;
    logic [XLEN-1:0]    srl_in;
    logic [XLEN-1:0]    sra_in;
    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    alu_out;

    assign rs1_addr = dec.rs1;
    assign rs2_addr = dec.rs2;

    assign imm = {{(XLEN-IMM_W){dec.imm[IMM_W-1]}}, dec.imm};

    always_comb begin
        case (dec.src_a)
            SRC_A_PC:   op_a = dec.pc;
            SRC_A_ZERO: op_a = '0;
            default:    op_a = rs1_data;
        endcase
    end

    assign op_b = (dec.src_b == SRC_B_IMM) ? imm : rs2_data;

    // word ops shift by 5 bits of the low half
    assign shamt  = dec.word_op ? SHAMT_W'(op_b[SHAMT_W-2:0]) : op_b[SHAMT_W-1:0];
    assign srl_in = dec.word_op ? {{(XLEN-WORD_W){1'b0}}, op_a[WORD_W-1:0]} : op_a;
    assign sra_in = dec.word_op ? {{(XLEN-WORD_W){op_a[WORD_W-1]}}, op_a[WORD_W-1:0]}
                                : op_a;

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  alu_out = op_a + op_b;
            ALU_SUB:  alu_out = op_a - op_b;
            ALU_SLL:  alu_out = op_a << shamt;
            ALU_SLT:  alu_out = XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLTU: alu_out = XLEN'(op_a < op_b);
            ALU_XOR:  alu_out = op_a ^ op_b;
            ALU_SRL:  alu_out = srl_in >> shamt;
            ALU_SRA:  alu_out = $signed(sra_in) >>> shamt;
            ALU_OR:   alu_out = op_a | op_b;
            ALU_AND:  alu_out = op_a & op_b;
            ALU_BEQ:  alu_out = XLEN'(op_a == op_b);
            ALU_BNE:  alu_out = XLEN'(op_a != op_b);
            ALU_BLT:  alu_out = XLEN'($signed(op_a) < $signed(op_b));
            ALU_BGE:  alu_out = XLEN'($signed(op_a) >= $signed(op_b));
            ALU_BLTU: alu_out = XLEN'(op_a < op_b);
            ALU_BGEU: alu_out = XLEN'(op_a >= op_b);
            default:  alu_out = '0;
        endcase
    end

    always_comb begin
        exe.valid    = dec.valid;
        exe.pc       = dec.pc;
        exe.inst     = dec.inst;
        exe.rd       = dec.rd;
        exe.reg_wen  = dec.reg_wen;
        exe.word_op  = dec.word_op;
        exe.value    = dec.is_jump ? dec.pc + XLEN'(4) : alu_out;  // link value
        exe.redirect = dec.is_jump || (dec.is_branch && alu_out[0]);
        exe.target   = dec.is_jalr ? {alu_out[XLEN-1:1], 1'b0} : dec.pc + imm;
        exe.trap     = dec.trap;
    end

endmodule

// File: rv_decode.sv
`timescale 1ns/10ps

module rv_decode import rv_isa_pkg::*, rv_core_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            inst_valid,
    input  logic [ILEN-1:0] inst,
    input  logic [XLEN-1:0] pc,
    output decoded_t        dec
);

    opcode_e             opcode;
    logic [FUNCT3_W-1:0] funct3;
    logic [FUNCT7_W-1:0] funct7;
    logic [IMM_W-1:0]    imm_i;
    logic [IMM_W-1:0]    imm_u;
    logic [IMM_W-1:0]    imm_j;
    logic [IMM_W-1:0]    imm_b;
    logic                illegal;
    decoded_t            dec_next;

    function automatic alu_op_e arith_op(input logic [FUNCT3_W-1:0] f3, input logic alt);
        alu_op_e op;
        case (alu_f3_e'(f3))
            F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = opcode_e'(inst[OPCODE_W-1:0]);
    assign funct3 = inst[FUNCT3_BASE +: FUNCT3_W];
    assign funct7 = inst[FUNCT7_BASE +: FUNCT7_W];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

    always_comb begin
        dec_next        = '0;
        dec_next.valid  = inst_valid;
        dec_next.pc     = pc;
        dec_next.inst   = inst;
        dec_next.rs1    = inst[RS1_BASE +: REG_ADDR_W];
        dec_next.rs2    = inst[RS2_BASE +: REG_ADDR_W];
        dec_next.rd     = inst[RD_BASE +: REG_ADDR_W];
        dec_next.imm    = imm_i;
        dec_next.alu_op = ALU_ADD;
        dec_next.src_a  = SRC_A_RS1;
        dec_next.src_b  = SRC_B_RS2;
        dec_next.trap   = TRAP_NONE;
        illegal         = 1'b0;
        case (opcode)
            OPC_OP, OPC_OP_32: begin
                dec_next.reg_wen = 1'b1;
                dec_next.word_op = (opcode == OPC_OP_32);
                dec_next.alu_op  = arith_op(funct3, funct7 == F7_ALT);
                if (funct7 == F7_ALT)
                    illegal = !(funct3 inside {F3_ADD, F3_SR});
                else
                    illegal = (funct7 != F7_BASE);  // mul/div end up here
                if (dec_next.word_op && !(funct3 inside {F3_ADD, F3_SLL, F3_SR}))
                    illegal = 1'b1;
            end
            OPC_OP_IMM: begin
                dec_next.reg_wen = 1'b1;
                dec_next.src_b   = SRC_B_IMM;
                dec_next.alu_op  = arith_op(funct3, funct3 == F3_SR && funct7[5]);
                // 6-bit shamt leaves funct6 in the top bits
                if (funct3 == F3_SLL)
                    illegal = (funct7[FUNCT7_W-1:1] != F7_BASE[FUNCT7_W-1:1]);
                else if (funct3 == F3_SR)
                    illegal = (funct7[FUNCT7_W-1:1] != F7_BASE[FUNCT7_W-1:1])
                           && (funct7[FUNCT7_W-1:1] != F7_ALT[FUNCT7_W-1:1]);
            end
            OPC_OP_IMM_32: begin
                dec_next.reg_wen = 1'b1;
                dec_next.word_op = 1'b1;
                dec_next.src_b   = SRC_B_IMM;
                dec_next.alu_op  = arith_op(funct3, funct3 == F3_SR && funct7 == F7_ALT);
                case (funct3)
                    F3_ADD:  illegal = 1'b0;
                    F3_SLL:  illegal = (funct7 != F7_BASE);
                    F3_SR:   illegal = (funct7 != F7_BASE) && (funct7 != F7_ALT);
                    default: illegal = 1'b1;
                endcase
            end
            OPC_LUI: begin
                dec_next.reg_wen = 1'b1;
                dec_next.imm     = imm_u;
                dec_next.src_a   = SRC_A_ZERO;
                dec_next.src_b   = SRC_B_IMM;
            end
            OPC_AUIPC: begin
                dec_next.reg_wen = 1'b1;
                dec_next.imm     = imm_u;
                dec_next.src_a   = SRC_A_PC;
                dec_next.src_b   = SRC_B_IMM;
            end
            OPC_JAL: begin
                dec_next.reg_wen = 1'b1;
                dec_next.is_jump = 1'b1;
                dec_next.imm     = imm_j;
            end
            OPC_JALR: begin
                dec_next.reg_wen = 1'b1;
                dec_next.is_jump = 1'b1;
                dec_next.is_jalr = 1'b1;
                dec_next.src_b   = SRC_B_IMM;  // rs1 + imm through the alu
                illegal          = (funct3 != '0);
            end
            OPC_BRANCH: begin
                dec_next.is_branch = 1'b1;
                dec_next.imm       = imm_b;
                case (branch_f3_e'(funct3))
                    F3_BEQ:  dec_next.alu_op = ALU_BEQ;
                    F3_BNE:  dec_next.alu_op = ALU_BNE;
                    F3_BLT:  dec_next.alu_op = ALU_BLT;
                    F3_BGE:  dec_next.alu_op = ALU_BGE;
                    F3_BLTU: dec_next.alu_op = ALU_BLTU;
                    F3_BGEU: dec_next.alu_op = ALU_BGEU;
                    default: illegal = 1'b1;
                endcase
            end
            default: begin
                if (inst == EBREAK_INST)
                    dec_next.trap = TRAP_EBREAK;
                else
                    illegal = 1'b1;
            end
        endcase
        if (illegal)
            dec_next.trap = TRAP_ILLEGAL;
        if (dec_next.trap != TRAP_NONE) begin  // no side effects on a trap
            dec_next.reg_wen   = 1'b0;
            dec_next.is_branch = 1'b0;
            dec_next.is_jump   = 1'b0;
            dec_next.is_jalr   = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            dec <= '0;
        else
            dec <= dec_next;
    end

endmodule

// File: rv_core_pkg.sv
package rv_core_pkg;

    import rv_isa_pkg::*;

    localparam int XLEN     = 64;
    localparam int WORD_W   = 32;
    localparam int IMM_W    = 32;
    localparam int NUM_REGS = 32;
    localparam int SHAMT_W  = 6;

    typedef logic [ILEN-1:0]       inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_A_RS1,
        SRC_A_ZERO,
        SRC_A_PC
    } src_a_e;

    typedef enum logic [1:0] {
        SRC_B_RS2,
        SRC_B_IMM
    } src_b_e;

    typedef enum logic [1:0] {
        TRAP_NONE,
        TRAP_ILLEGAL,
        TRAP_EBREAK
    } trap_e;

    typedef struct packed {
        logic             valid;
        logic [XLEN-1:0]  pc;
        inst_t            inst;
        reg_addr_t        rs1;
        reg_addr_t        rs2;
        reg_addr_t        rd;
        logic [IMM_W-1:0] imm;      // sign extended in execute
        alu_op_e          alu_op;
        src_a_e           src_a;
        src_b_e           src_b;
        logic             word_op;
        logic             reg_wen;
        logic             is_branch;
        logic             is_jump;
        logic             is_jalr;
        trap_e            trap;
    } decoded_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        inst_t           inst;
        reg_addr_t       rd;
        logic            reg_wen;
        logic            word_op;
        logic [XLEN-1:0] value;
        logic            redirect;
        logic [XLEN-1:0] target;
        trap_e           trap;
    } exec_result_t;

endpackage

// File: rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int ILEN = 32;

    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT7_W   = 7;
    localparam int REG_ADDR_W = 5;

    localparam int RD_BASE     = 7;
    localparam int FUNCT3_BASE = 12;
    localparam int RS1_BASE    = 15;
    localparam int RS2_BASE    = 20;
    localparam int FUNCT7_BASE = 25;

    localparam logic [ILEN-1:0] EBREAK_INST = 32'h0010_0073;

    localparam logic [FUNCT7_W-1:0] F7_BASE = 7'b0000000;
    localparam logic [FUNCT7_W-1:0] F7_ALT  = 7'b0100000;  // sub / sra

    typedef enum logic [OPCODE_W-1:0] {
        OPC_OP        = 7'b0110011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_OP_32     = 7'b0111011,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111,
        OPC_BRANCH    = 7'b1100011
    } opcode_e;

    typedef enum logic [FUNCT3_W-1:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,  // srl and sra
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } alu_f3_e;

    typedef enum logic [FUNCT3_W-1:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } branch_f3_e;

endpackage
